// ==== common/trk_cfg.svh ====
//====================================================================
// Track geometry and field widths for the track buffer
//====================================================================
`ifndef TRK_CFG_SVH
`define TRK_CFG_SVH

// Track geometry
`define TRK_SECTORS      17                              // Sectors per track
`define TRK_SECTOR_BYTES 512                             // Bytes per sector
`define TRK_BUF_BYTES    (`TRK_SECTORS * `TRK_SECTOR_BYTES)

// Field widths
`define TRK_ADDR_W       14   // Buffer byte address
`define TRK_CYL_W        16
`define TRK_HEAD_W       4

`endif

// ==== common/trk_geom_pkg.sv ====
//====================================================================
// Geometry types: sector and byte indices, buffer and disk addresses
//====================================================================
`default_nettype none
`include "trk_cfg.svh"

package trk_geom_pkg;

    typedef logic [7:0] data_byte_t;

    // 0-based sector slot in the buffer
    typedef logic [$clog2(`TRK_SECTORS)-1:0] sector_idx_t;

    // Offset inside one sector
    typedef logic [$clog2(`TRK_SECTOR_BYTES)-1:0] byte_idx_t;

    typedef logic [`TRK_ADDR_W-1:0] buf_addr_t;

    // One flag per sector, bit 0 is sector 1
    typedef logic [`TRK_SECTORS-1:0] sector_map_t;

    // Disk address, sector number is 1-based as on the drive
    typedef struct packed {
        logic [`TRK_CYL_W-1:0]  cyl;
        logic [`TRK_HEAD_W-1:0] head;
        logic [7:0]             sector;
    } chs_t;

endpackage

`default_nettype wire

// ==== common/trk_cmd_pkg.sv ====
//====================================================================
// Request, job and command structs passed between the blocks
//====================================================================
`default_nettype none

package trk_cmd_pkg;

    import trk_geom_pkg::*;

    // Request from the command FSM
    typedef struct packed {
        logic fill_start;    // Host reads the sector
        logic flush_start;   // Host writes the sector
        chs_t target;
    } buf_req_t;

    // Job for the host side
    typedef struct packed {
        logic        go;       // One-cycle start
        logic        write;    // 1 = host writes into the buffer
        sector_idx_t sector;
    } host_xfer_t;

    // Job for the disk side
    typedef struct packed {
        logic go;
        logic write;   // 1 = buffer to disk
        chs_t chs;     // Flush uses dirty index plus 1
    } disk_job_t;

    // Command lines to the drive
    typedef struct packed {
        logic read_start;
        logic write_start;
        chs_t chs;
    } disk_cmd_t;

endpackage

`default_nettype wire

// ==== verilog/sector_ram.sv ====
//====================================================================
// Dual-port byte RAM holding one track of sectors
//====================================================================
`timescale 1ns/1ps
`default_nettype none
`include "trk_cfg.svh"

module sector_ram (
    input  logic                     clk,
    input  trk_geom_pkg::buf_addr_t  a_addr,    // Host side
    input  logic                     a_we,
    input  trk_geom_pkg::data_byte_t a_wdata,
    output trk_geom_pkg::data_byte_t a_rdata,
    input  trk_geom_pkg::buf_addr_t  b_addr,    // Disk side
    input  logic                     b_we,
    input  trk_geom_pkg::data_byte_t b_wdata,
    output trk_geom_pkg::data_byte_t b_rdata
);
    import trk_geom_pkg::*;

    data_byte_t mem [`TRK_BUF_BYTES];

    // Both write ports, never active together
    always_ff @(posedge clk) begin
        if (a_we)
            mem[a_addr] <= a_wdata;
        if (b_we)
            mem[b_addr] <= b_wdata;
    end

    assign a_rdata = mem[a_addr];   // Async read
    assign b_rdata = mem[b_addr];

endmodule

`default_nettype wire

// ==== host_port/host_port.sv ====
//====================================================================
// Host side sector transfer over RAM port A
//====================================================================
`timescale 1ns/1ps
`default_nettype none
`include "trk_cfg.svh"

module host_port (
    input  logic                     clk,
    input  logic                     reset_n,
    input  trk_cmd_pkg::host_xfer_t  host_xfer,   // Job from the controller
    input  logic                     host_read,   // Byte strobes from host
    input  logic                     host_write,
    input  trk_geom_pkg::data_byte_t host_wdata,
    output trk_geom_pkg::data_byte_t host_rdata,
    output logic                     host_drq,
    output logic                     host_done,
    output trk_geom_pkg::buf_addr_t  a_addr,
    output logic                     a_we,
    output trk_geom_pkg::data_byte_t a_wdata,
    input  trk_geom_pkg::data_byte_t a_rdata
);
    import trk_geom_pkg::*;

    logic        active;       // Transfer running
    logic        xfer_wr;
    sector_idx_t xfer_sector;
    byte_idx_t   byte_cnt;
    logic        step;         // Byte moved this cycle
    logic        last_byte;

    // Only the strobe matching the direction counts
    assign step      = active && (xfer_wr ? host_write : host_read);
    assign last_byte = (byte_cnt == byte_idx_t'(`TRK_SECTOR_BYTES - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active    <= 1'b0;
            host_done <= 1'b0;
            byte_cnt  <= '0;
        end else begin
            host_done <= 1'b0;
            if (host_xfer.go) begin
                active   <= 1'b1;
                byte_cnt <= '0;
            end else if (step) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (last_byte) begin
                    active    <= 1'b0;  // 512th byte seen
                    host_done <= 1'b1;
                end
            end
        end
    end

    // Job latch
    always_ff @(posedge clk) begin
        if (host_xfer.go) begin
            xfer_wr     <= host_xfer.write;
            xfer_sector <= host_xfer.sector;
        end
    end

    assign host_drq   = active;
    assign a_addr     = {xfer_sector, byte_cnt};   // Sector base plus offset
    assign a_we       = step && xfer_wr;
    assign a_wdata    = host_wdata;
    assign host_rdata = a_rdata;

endmodule

`default_nettype wire

// ==== cache_ctrl/track_cache_ctrl.sv ====
//====================================================================
// Track cache FSM with valid and dirty bitmaps
// Hit and miss decisions, write-back of dirty sectors on track change
//====================================================================
`timescale 1ns/1ps
`default_nettype none
`include "trk_cfg.svh"

module track_cache_ctrl (
    input  logic                    clk,
    input  logic                    reset_n,
    input  trk_cmd_pkg::buf_req_t   buf_req,
    output logic                    buf_ready,
    output logic                    buf_error,
    output trk_cmd_pkg::host_xfer_t host_xfer,
    input  logic                    host_done,
    output trk_cmd_pkg::disk_job_t  disk_job,
    input  logic                    job_done,
    input  logic                    job_error
);
    import trk_geom_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,       // Register track and bitmap compares
        ST_DECIDE,       // Hit or miss
        ST_FLUSH_PICK,   // Next dirty sector, or retarget when clean
        ST_FLUSH_WAIT,
        ST_FILL_START,
        ST_FILL_WAIT,
        ST_HOST_WAIT
    } state_t;

    state_t state;

    // Cache bookkeeping
    chs_t        cached_chs;   // Track in the buffer
    logic        cache_empty;
    sector_map_t valid_map;
    sector_map_t dirty_map;

    // Current request
    chs_t        req_chs;
    logic        req_wr;
    sector_idx_t req_idx;
    logic        same_trk;
    logic        sec_hit;
    logic        bad_sec;

    // Job outputs
    logic        host_go;
    logic        job_go;
    logic        job_wr;
    chs_t        job_chs;
    sector_idx_t flush_idx;
    sector_idx_t flush_next;

    // Lowest set bit, scanned from the top so bit 0 wins
    function automatic sector_idx_t lowest_set(input sector_map_t map);
        sector_idx_t idx;
        idx = '0;
        for (int i = `TRK_SECTORS - 1; i >= 0; i--) begin
            if (map[i])
                idx = sector_idx_t'(i);
        end
        return idx;
    endfunction

    assign req_idx    = sector_idx_t'(req_chs.sector - 8'd1);
    assign flush_next = lowest_set(dirty_map);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= ST_IDLE;
            buf_ready   <= 1'b0;
            buf_error   <= 1'b0;
            host_go     <= 1'b0;
            job_go      <= 1'b0;
            job_wr      <= 1'b0;
            job_chs     <= '0;
            cached_chs  <= '0;
            cache_empty <= 1'b1;
            valid_map   <= '0;
            dirty_map   <= '0;
            req_chs     <= '0;
            req_wr      <= 1'b0;
            same_trk    <= 1'b0;
            sec_hit     <= 1'b0;
            bad_sec     <= 1'b0;
            flush_idx   <= '0;
        end else begin
            // One-cycle pulses
            buf_ready <= 1'b0;
            buf_error <= 1'b0;
            host_go   <= 1'b0;
            job_go    <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (buf_req.fill_start || buf_req.flush_start) begin
                        req_chs <= buf_req.target;
                        req_wr  <= buf_req.flush_start;
                        state   <= ST_LOOKUP;
                    end
                end

                ST_LOOKUP: begin
                    same_trk <= !cache_empty && (req_chs.cyl == cached_chs.cyl) &&
                                (req_chs.head == cached_chs.head);
                    bad_sec  <= (req_chs.sector == 8'd0) ||
                                (req_chs.sector > 8'(`TRK_SECTORS));
                    // Dirty sector holds newer host data, never refill it
                    sec_hit  <= req_wr ? dirty_map[req_idx] : valid_map[req_idx];
                    state    <= ST_DECIDE;
                end

                ST_DECIDE: begin
                    if (bad_sec) begin
                        buf_error <= 1'b1;      // Sector outside the track
                        state     <= ST_IDLE;
                    end else if (same_trk && sec_hit) begin
                        host_go <= 1'b1;        // Straight to the host
                        state   <= ST_HOST_WAIT;
                    end else if (same_trk) begin
                        state <= ST_FILL_START;
                    end else begin
                        state <= ST_FLUSH_PICK; // Track change
                    end
                end

                //====================================================================
                // Write-back, lowest dirty sector first
                //====================================================================
                ST_FLUSH_PICK: begin
                    if (dirty_map != '0) begin
                        flush_idx <= flush_next;
                        job_go    <= 1'b1;
                        job_wr    <= 1'b1;
                        job_chs   <= '{cyl:    cached_chs.cyl,
                                       head:   cached_chs.head,
                                       sector: 8'(flush_next) + 8'd1};
                        state     <= ST_FLUSH_WAIT;
                    end else begin
                        // All clean, take over the new track
                        cached_chs  <= req_chs;
                        cache_empty <= 1'b0;
                        valid_map   <= '0;
                        state       <= ST_FILL_START;
                    end
                end

                ST_FLUSH_WAIT: begin
                    if (job_error) begin
                        buf_error <= 1'b1;      // Bitmaps untouched
                        state     <= ST_IDLE;
                    end else if (job_done) begin
                        dirty_map[flush_idx] <= 1'b0;
                        state                <= ST_FLUSH_PICK;
                    end
                end

                //====================================================================
                // Fill and host transfer
                //====================================================================
                ST_FILL_START: begin
                    job_go  <= 1'b1;
                    job_wr  <= 1'b0;
                    job_chs <= req_chs;
                    state   <= ST_FILL_WAIT;
                end

                ST_FILL_WAIT: begin
                    if (job_error) begin
                        buf_error <= 1'b1;
                        state     <= ST_IDLE;
                    end else if (job_done) begin
                        valid_map[req_idx] <= 1'b1;
                        host_go            <= 1'b1;
                        state              <= ST_HOST_WAIT;
                    end
                end

                ST_HOST_WAIT: begin
                    if (host_done) begin
                        if (req_wr) begin
                            valid_map[req_idx] <= 1'b1;
                            dirty_map[req_idx] <= 1'b1;
                        end
                        buf_ready <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    assign host_xfer = '{go: host_go, write: req_wr, sector: req_idx};
    assign disk_job  = '{go: job_go, write: job_wr, chs: job_chs};

endmodule

`default_nettype wire

// ==== disk_port/disk_port.sv ====
//====================================================================
// Disk side sector transfer over RAM port B
//====================================================================
`timescale 1ns/1ps
`default_nettype none
`include "trk_cfg.svh"

module disk_port (
    input  logic                     clk,
    input  logic                     reset_n,
    input  trk_cmd_pkg::disk_job_t   disk_job,
    output logic                     job_done,
    output logic                     job_error,
    output trk_cmd_pkg::disk_cmd_t   disk_cmd,
    input  logic                     disk_ready,      // Ends the job
    input  logic                     disk_error,
    input  logic                     disk_byte_valid,
    input  trk_geom_pkg::data_byte_t disk_rdata,
    output trk_geom_pkg::data_byte_t disk_wdata,
    output logic                     disk_byte_ack,
    output trk_geom_pkg::buf_addr_t  b_addr,
    output logic                     b_we,
    output trk_geom_pkg::data_byte_t b_wdata,
    input  trk_geom_pkg::data_byte_t b_rdata
);
    import trk_geom_pkg::*;

    logic        active;
    logic        job_wr;     // Direction of the running job
    byte_idx_t   byte_cnt;
    sector_idx_t sec_idx;
    logic        take;       // Byte handed over this cycle

    // Valid counts once, the ack masks the held strobe
    assign take    = active && disk_byte_valid && !disk_byte_ack;
    assign sec_idx = sector_idx_t'(disk_cmd.chs.sector - 8'd1);   // 1-based on disk

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active        <= 1'b0;
            job_wr        <= 1'b0;
            byte_cnt      <= '0;
            disk_cmd      <= '0;
            disk_byte_ack <= 1'b0;
            job_done      <= 1'b0;
            job_error     <= 1'b0;
        end else begin
            disk_cmd.read_start  <= 1'b0;
            disk_cmd.write_start <= 1'b0;
            disk_byte_ack        <= 1'b0;
            job_done             <= 1'b0;
            job_error            <= 1'b0;

            if (disk_job.go) begin
                active               <= 1'b1;
                job_wr               <= disk_job.write;
                byte_cnt             <= '0;
                disk_cmd.chs         <= disk_job.chs;      // Held until next job
                disk_cmd.read_start  <= !disk_job.write;
                disk_cmd.write_start <= disk_job.write;
            end else if (active) begin
                if (disk_error) begin
                    active    <= 1'b0;
                    job_error <= 1'b1;
                end else if (disk_ready) begin
                    active   <= 1'b0;
                    job_done <= 1'b1;
                end else if (take) begin
                    disk_byte_ack <= 1'b1;                 // Ack next cycle
                    byte_cnt      <= byte_cnt + 1'b1;
                end
            end
        end
    end

    assign b_addr     = {sec_idx, byte_cnt};
    assign b_we       = take && !job_wr;    // Store read stream
    assign b_wdata    = disk_rdata;
    assign disk_wdata = b_rdata;            // Write stream, current index

endmodule

`default_nettype wire

// ==== verilog/track_buffer.sv ====
//====================================================================
// Track buffer top, cache FSM with host, disk and RAM blocks
//====================================================================
`timescale 1ns/1ps
`default_nettype none
`include "trk_cfg.svh"

module track_buffer (
    input  logic                     clk,
    input  logic                     reset_n,
    // Controller
    input  trk_cmd_pkg::buf_req_t    buf_req,
    output logic                     buf_ready,
    output logic                     buf_error,
    // Host
    input  logic                     host_read,
    input  logic                     host_write,
    input  trk_geom_pkg::data_byte_t host_wdata,
    output trk_geom_pkg::data_byte_t host_rdata,
    output logic                     host_drq,
    // Disk
    output trk_cmd_pkg::disk_cmd_t   disk_cmd,
    input  logic                     disk_ready,
    input  logic                     disk_error,
    input  logic                     disk_byte_valid,
    input  trk_geom_pkg::data_byte_t disk_rdata,
    output trk_geom_pkg::data_byte_t disk_wdata,
    output logic                     disk_byte_ack
);
    import trk_geom_pkg::*;
    import trk_cmd_pkg::*;

    host_xfer_t host_xfer;
    logic       host_done;
    disk_job_t  disk_job;
    logic       job_done;
    logic       job_error;

    // RAM ports
    buf_addr_t  a_addr;
    logic       a_we;
    data_byte_t a_wdata;
    data_byte_t a_rdata;
    buf_addr_t  b_addr;
    logic       b_we;
    data_byte_t b_wdata;
    data_byte_t b_rdata;

    track_cache_ctrl track_cache_ctrl_i (
        .clk, .reset_n, .buf_req, .buf_ready, .buf_error,
        .host_xfer, .host_done, .disk_job, .job_done, .job_error
    );

    host_port host_port_i (
        .clk, .reset_n, .host_xfer, .host_read, .host_write, .host_wdata,
        .host_rdata, .host_drq, .host_done, .a_addr, .a_we, .a_wdata, .a_rdata
    );

    disk_port disk_port_i (
        .clk, .reset_n, .disk_job, .job_done, .job_error, .disk_cmd,
        .disk_ready, .disk_error, .disk_byte_valid, .disk_rdata, .disk_wdata,
        .disk_byte_ack, .b_addr, .b_we, .b_wdata, .b_rdata
    );

    sector_ram sector_ram_i (
        .clk, .a_addr, .a_we, .a_wdata, .a_rdata,
        .b_addr, .b_we, .b_wdata, .b_rdata
    );

endmodule

`default_nettype wire

// ==== test/tb_disk_model.sv ====
//====================================================================
// Behavioral disk drive for the track buffer testbench
// Serves pattern sectors, logs write jobs, injects disk errors
//====================================================================
`timescale 1ns/1ps
`default_nettype none
`include "trk_cfg.svh"

module tb_disk_model (
    input  logic                     clk,
    input  trk_cmd_pkg::disk_cmd_t   disk_cmd,
    input  trk_geom_pkg::data_byte_t disk_wdata,
    input  logic                     disk_byte_ack,
    input  logic                     fail_next,        // Answer next job with disk_error
    output logic                     disk_ready,
    output logic                     disk_error,
    output logic                     disk_byte_valid,
    output trk_geom_pkg::data_byte_t disk_rdata,
    output logic                     fault             // Ack never came
);
    import trk_geom_pkg::*;
    import trk_cmd_pkg::*;

    localparam int SEC_BYTES = `TRK_SECTOR_BYTES;

    // Job log, read by the testbench top
    int         rd_jobs;
    int         wr_jobs;
    chs_t       rd_chs   [16];
    int         rd_order [16];           // Write jobs seen before each read
    chs_t       wr_chs   [8];
    data_byte_t wr_data  [8 * SEC_BYTES];

    // Stored image of every track on the drive
    function automatic data_byte_t track_byte(input chs_t chs, input int i);
        return data_byte_t'(int'(chs.cyl) * 37 + int'(chs.sector) * 11 + i);
    endfunction

    // One byte over valid and ack
    task automatic move_byte(input data_byte_t rd, output data_byte_t wr, output logic ok);
        int wait_n;
        ok = 1'b0;
        repeat ($urandom_range(3, 1)) @(negedge clk);   // Random gap before valid
        disk_rdata      = rd;
        disk_byte_valid = 1'b1;
        wr              = disk_wdata;    // Index stable since the last rising edge
        wait_n          = 0;
        while (!ok && wait_n < 16) begin
            @(negedge clk);
            ok = disk_byte_ack;
            wait_n++;
        end
        disk_byte_valid = 1'b0;
    endtask

    task automatic serve_job();
        chs_t       chs;
        logic       wr;
        logic       err;
        logic       ok;
        data_byte_t got;
        int         base;
        int         n_bytes;
        int         i;
        chs  = disk_cmd.chs;
        wr   = disk_cmd.write_start;
        err  = fail_next;
        base = (wr_jobs % 8) * SEC_BYTES;
        if (wr) begin
            wr_chs[wr_jobs % 8] = chs;
            wr_jobs++;
        end else begin
            rd_chs[rd_jobs % 16]   = chs;
            rd_order[rd_jobs % 16] = wr_jobs;
            rd_jobs++;
        end
        n_bytes = err ? 8 : SEC_BYTES;   // Failing job breaks off early
        ok      = 1'b1;
        for (i = 0; i < n_bytes && ok; i++) begin
            move_byte(track_byte(chs, i), got, ok);
            if (wr)
                wr_data[base + i] = got;
        end
        fault = !ok;
        @(negedge clk);
        disk_error = err;                // End of job, one cycle
        disk_ready = !err;
        @(negedge clk);
        disk_error = 1'b0;
        disk_ready = 1'b0;
    endtask

    initial begin
        disk_ready      = 1'b0;
        disk_error      = 1'b0;
        disk_byte_valid = 1'b0;
        disk_rdata      = '0;
        fault           = 1'b0;
        rd_jobs         = 0;
        wr_jobs         = 0;
        forever begin
            @(negedge clk);
            if (disk_cmd.read_start || disk_cmd.write_start)
                serve_job();
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_track_buffer.sv ====
//====================================================================
// Testbench top with clock, reset and the directed track buffer tests
//====================================================================
`timescale 1ns/1ps
`default_nettype none
`include "trk_cfg.svh"

module tb_track_buffer;
    import trk_geom_pkg::*;
    import trk_cmd_pkg::*;

    localparam int SEC_BYTES = `TRK_SECTOR_BYTES;
    localparam int TIMEOUT   = 20000;   // Cycles allowed per wait

    logic       clk;
    logic       reset_n;
    buf_req_t   buf_req;
    logic       buf_ready;
    logic       buf_error;
    logic       host_read;
    logic       host_write;
    data_byte_t host_wdata;
    data_byte_t host_rdata;
    logic       host_drq;
    disk_cmd_t  disk_cmd;
    logic       disk_ready;
    logic       disk_error;
    logic       disk_byte_valid;
    data_byte_t disk_rdata;
    data_byte_t disk_wdata;
    logic       disk_byte_ack;
    logic       fail_next;
    logic       model_fault;

    data_byte_t expect_buf [SEC_BYTES];   // Bytes the host should read
    data_byte_t image_buf  [SEC_BYTES];   // Bytes the host writes
    data_byte_t image_s1   [SEC_BYTES];
    data_byte_t image_s3   [SEC_BYTES];

    track_buffer track_buffer_i (
        .clk, .reset_n, .buf_req, .buf_ready, .buf_error, .host_read, .host_write,
        .host_wdata, .host_rdata, .host_drq, .disk_cmd, .disk_ready, .disk_error,
        .disk_byte_valid, .disk_rdata, .disk_wdata, .disk_byte_ack
    );

    tb_disk_model disk_model_i (
        .clk, .disk_cmd, .disk_wdata, .disk_byte_ack, .fail_next, .disk_ready,
        .disk_error, .disk_byte_valid, .disk_rdata, .fault(model_fault)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 100 MHz
    end

    //======================================================================
    // Reporting and compares
    //======================================================================
    task automatic report_fail(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input data_byte_t got, input data_byte_t exp);
        if (got !== exp)
            report_fail($sformatf("mismatch at %0t: %s got %02h expected %02h",
                                  $time, name, got, exp));
    endtask

    task automatic check_chs(input string name, input chs_t got, input chs_t exp);
        if (got !== exp)
            report_fail($sformatf("mismatch at %0t: %s got %0d/%0d/%0d expected %0d/%0d/%0d",
                                  $time, name, got.cyl, got.head, got.sector,
                                  exp.cyl, exp.head, exp.sector));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_fail($sformatf("mismatch at %0t: %s got %b expected %b",
                                  $time, name, got, exp));
    endtask

    // Running totals of disk starts
    task automatic check_jobs(input int rd_exp, input int wr_exp);
        if (disk_model_i.rd_jobs != rd_exp)
            report_fail($sformatf("mismatch at %0t: disk read starts got %0d expected %0d",
                                  $time, disk_model_i.rd_jobs, rd_exp));
        if (disk_model_i.wr_jobs != wr_exp)
            report_fail($sformatf("mismatch at %0t: disk write starts got %0d expected %0d",
                                  $time, disk_model_i.wr_jobs, wr_exp));
    endtask

    always @(negedge clk) begin
        if (model_fault)
            report_fail("disk model got no disk_byte_ack in time");
    end

    //======================================================================
    // Stimulus helpers entered and left on a falling edge
    //======================================================================
    function automatic chs_t make_chs(input int cyl, input int head, input int sector);
        chs_t c;
        c.cyl    = cyl[`TRK_CYL_W-1:0];
        c.head   = head[`TRK_HEAD_W-1:0];
        c.sector = sector[7:0];
        return c;
    endfunction

    // Pattern stored on the drive for byte i of sector s on cylinder c
    task automatic load_pattern(input chs_t chs);
        int i;
        for (i = 0; i < SEC_BYTES; i++)
            expect_buf[i] = data_byte_t'(int'(chs.cyl) * 37 + int'(chs.sector) * 11 + i);
    endtask

    task automatic issue_request(input logic wr, input chs_t chs);
        buf_req = '{fill_start: !wr, flush_start: wr, target: chs};
        @(negedge clk);
        buf_req = '0;   // One-cycle pulse
    endtask

    task automatic await_reply(input logic want_error);
        int n;
        n = 0;
        while (!buf_ready && !buf_error) begin
            if (n == TIMEOUT)
                report_fail("neither buf_ready nor buf_error arrived in time");
            @(negedge clk);
            n++;
        end
        check_bit("buf_error", buf_error, want_error);
        check_bit("buf_ready", buf_ready, !want_error);
        @(negedge clk);
    endtask

    task automatic wait_drq();
        int n;
        n = 0;
        while (!host_drq) begin
            if (n == TIMEOUT)
                report_fail("host_drq never rose for the host transfer");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic host_read_sector();
        int i;
        wait_drq();
        for (i = 0; i < SEC_BYTES; i++) begin
            check_byte($sformatf("host_rdata[%0d]", i), host_rdata, expect_buf[i]);
            host_read = 1'b1;   // Back to back strobes
            @(negedge clk);
        end
        host_read = 1'b0;
    endtask

    task automatic host_write_sector();
        int i;
        wait_drq();
        for (i = 0; i < SEC_BYTES; i++) begin
            host_wdata = image_buf[i];
            host_write = 1'b1;
            @(negedge clk);
        end
        host_write = 1'b0;
        host_wdata = '0;
    endtask

    task automatic random_image();
        int i;
        for (i = 0; i < SEC_BYTES; i++)
            image_buf[i] = data_byte_t'($urandom);
    endtask

    //======================================================================
    // Directed tests
    //======================================================================
    task automatic test_cold_read();
        chs_t chs;
        chs = make_chs(5, 2, 3);
        check_bit("host_drq", host_drq, 1'b0);
        check_bit("buf_ready", buf_ready, 1'b0);
        check_bit("buf_error", buf_error, 1'b0);
        check_bit("disk_cmd.read_start", disk_cmd.read_start, 1'b0);
        check_bit("disk_cmd.write_start", disk_cmd.write_start, 1'b0);
        check_bit("disk_byte_ack", disk_byte_ack, 1'b0);
        load_pattern(chs);
        issue_request(1'b0, chs);
        host_read_sector();
        await_reply(1'b0);
        check_jobs(1, 0);
        check_chs("disk_cmd.chs", disk_model_i.rd_chs[0], chs);
    endtask

    task automatic test_read_hit();
        chs_t chs;
        chs = make_chs(5, 2, 3);
        load_pattern(chs);
        issue_request(1'b0, chs);
        host_read_sector();
        await_reply(1'b0);
        check_jobs(1, 0);   // No disk access on a hit
    endtask

    task automatic test_write_fill();
        chs_t chs;
        chs = make_chs(5, 2, 3);
        random_image();
        image_s3 = image_buf;
        issue_request(1'b1, chs);
        host_write_sector();
        await_reply(1'b0);
        check_jobs(2, 0);   // Fill before the write
        check_chs("disk_cmd.chs", disk_model_i.rd_chs[1], chs);
        expect_buf = image_s3;
        issue_request(1'b0, chs);
        host_read_sector();
        await_reply(1'b0);
        check_jobs(2, 0);
    endtask

    task automatic test_track_change();
        chs_t chs51;
        chs_t chs53;
        chs_t chs63;
        int   i;
        chs51 = make_chs(5, 2, 1);
        chs53 = make_chs(5, 2, 3);
        chs63 = make_chs(6, 2, 3);
        random_image();
        image_s1 = image_buf;
        issue_request(1'b1, chs51);
        host_write_sector();
        await_reply(1'b0);
        check_jobs(3, 0);
        load_pattern(chs63);
        issue_request(1'b0, chs63);   // Other cylinder forces a write-back
        host_read_sector();
        await_reply(1'b0);
        check_jobs(4, 2);
        check_chs("write job 0 chs", disk_model_i.wr_chs[0], chs51);
        check_chs("write job 1 chs", disk_model_i.wr_chs[1], chs53);
        check_chs("disk_cmd.chs", disk_model_i.rd_chs[3], chs63);
        if (disk_model_i.rd_order[3] != 2)
            report_fail("fill of the new track started before the write-back ended");
        for (i = 0; i < SEC_BYTES; i++) begin
            check_byte($sformatf("sector 1 disk_wdata[%0d]", i),
                       disk_model_i.wr_data[i], image_s1[i]);
            check_byte($sformatf("sector 3 disk_wdata[%0d]", i),
                       disk_model_i.wr_data[SEC_BYTES + i], image_s3[i]);
        end
    endtask

    task automatic test_fill_error();
        chs_t chs;
        chs = make_chs(6, 2, 7);
        fail_next = 1'b1;
        issue_request(1'b0, chs);
        await_reply(1'b1);
        check_bit("host_drq", host_drq, 1'b0);
        fail_next = 1'b0;
        check_jobs(5, 2);
        load_pattern(chs);
        issue_request(1'b0, chs);     // Retry
        host_read_sector();
        await_reply(1'b0);
        check_jobs(6, 2);
        check_chs("disk_cmd.chs", disk_model_i.rd_chs[5], chs);
    endtask

    initial begin
        void'($urandom(32'h2bf4397d));   // One seed for the whole run
        reset_n    = 1'b0;
        buf_req    = '0;
        host_read  = 1'b0;
        host_write = 1'b0;
        host_wdata = '0;
        fail_next  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        test_cold_read();
        test_read_hit();
        test_write_fill();
        test_track_change();
        test_fill_error();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== track_buffer.f ====
+incdir+common
common/trk_geom_pkg.sv
common/trk_cmd_pkg.sv
verilog/sector_ram.sv
host_port/host_port.sv
cache_ctrl/track_cache_ctrl.sv
disk_port/disk_port.sv
verilog/track_buffer.sv
test/tb_disk_model.sv
test/tb_track_buffer.sv

// ==== Makefile ====
# Verilator simulation of the track buffer

VERILATOR ?= verilator
TOP       ?= tb_track_buffer
FILELIST  ?= track_buffer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
